//--- hdl/tti_core.sv
/* Interrupt and event logic; push monitors are delayed one cycle to line up with queue status.
   An ENEC and a DISEC on the same bit in one cycle leave the bit set. */
`timescale 1ns/1ps

module tti_core (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  tti_pkg::csr_fields_t  csr_i,
  output tti_pkg::core_fields_t core_o,
  input  tti_pkg::tgt_rx_t      tgt_rx_i,
  input  tti_pkg::tgt_evt_t     tgt_evt_i,
  input  tti_pkg::queue_sts_t   rx_desc_sts_i,
  input  tti_pkg::queue_sts_t   rx_data_sts_i,
  output logic                  irq_o
);

  logic                       desc_wr_q;
  logic                       data_wr_q;
  logic [tti_pkg::NumIrq-1:0] irq_set;
  logic [tti_pkg::NumIrq-1:0] irq_clr;
  logic [tti_pkg::NumIrq-1:0] irq_w1c;
  logic [tti_pkg::NumIrq-1:0] irq_sts;
  logic [tti_pkg::NumIrq-1:0] irq_out;

  // Queue level is valid one cycle after the push
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      desc_wr_q <= 1'b0;
      data_wr_q <= 1'b0;
    end else begin
      desc_wr_q <= tgt_rx_i.desc_wr;
      data_wr_q <= tgt_rx_i.data_wr;
    end
  end

  always_comb begin
    irq_set = '0;
    irq_clr = '0;

    irq_set[tti_pkg::RX_DESC_STAT] = desc_wr_q;
    irq_clr[tti_pkg::RX_DESC_STAT] = csr_i.rx_desc_pop;

    irq_set[tti_pkg::RX_DESC_THLD] = desc_wr_q & rx_desc_sts_i.thld_trig;
    irq_clr[tti_pkg::RX_DESC_THLD] = csr_i.rx_desc_pop;

    irq_set[tti_pkg::RX_DATA_THLD] = data_wr_q & rx_data_sts_i.thld_trig;
    irq_clr[tti_pkg::RX_DATA_THLD] = csr_i.rx_data_pop;

    // Private read done, cleared by software only
    irq_set[tti_pkg::TX_DONE] = tgt_evt_i.tx_pr_end;
    irq_clr[tti_pkg::TX_DONE] = 1'b0;
  end

  assign irq_w1c = csr_i.w1c_mask & {tti_pkg::NumIrq{csr_i.w1c_we}};

  for (genvar i = 0; i < tti_pkg::NumIrq; i++) begin : g_intr
    tti_intr i_intr (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .set_i   (irq_set[i]),
      .clr_i   (irq_clr[i]),
      .w1c_i   (irq_w1c[i]),
      .force_i (csr_i.irq_force[i]),
      .ena_i   (csr_i.irq_ena[i]),
      .sts_o   (irq_sts[i]),
      .irq_o   (irq_out[i])
    );
  end

  // ENEC drives a 1 into the bit, DISEC alone drives a 0
  assign core_o.ctrl_we   = tgt_evt_i.enec | tgt_evt_i.disec;
  assign core_o.ctrl_next = tgt_evt_i.enec;
  assign core_o.err_set   = tgt_evt_i.err;
  assign core_o.irq_sts   = irq_sts;

  assign irq_o = |irq_out;

endmodule

//--- hdl/tti_csr.sv
/* Wishbone classic slave, word accesses only; ack comes one cycle after the request.
   Unmapped offsets read 0 and drop writes; a read of an empty port returns 0. */
`timescale 1ns/1ps

module tti_csr (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  tti_pkg::wb_req_t              wb_req_i,
  output tti_pkg::wb_rsp_t              wb_rsp_o,
  input  tti_pkg::core_fields_t         core_i,
  output tti_pkg::csr_fields_t          csr_o,
  input  logic [tti_pkg::DataWidth-1:0] rx_desc_head_i,
  input  logic [tti_pkg::DataWidth-1:0] rx_data_head_i,
  input  tti_pkg::queue_sts_t           rx_desc_sts_i,
  input  tti_pkg::queue_sts_t           rx_data_sts_i,
  output logic [tti_pkg::DataWidth-1:0] tx_wdata_o
);

  logic                               ack_q;
  logic                               req;
  logic                               wr;
  logic                               rd;
  logic [tti_pkg::DataWidth-1:0]      rdata_d;
  logic [tti_pkg::DataWidth-1:0]      rdata_q;
  logic [tti_pkg::NumCtrl-1:0]        ctrl_q;
  logic                               err_q;
  logic [tti_pkg::NumIrq-1:0]         ena_q;
  logic [tti_pkg::NumIrq-1:0]         force_q;
  logic [tti_pkg::FieldThldWidth-1:0] desc_thld_q;
  logic [tti_pkg::FieldThldWidth-1:0] data_thld_q;
  logic [2:0]                         rst_ctrl_q;

  // Request is taken once, ack masks the hold cycle
  assign req = wb_req_i.cyc & wb_req_i.stb & ~ack_q;
  assign wr  = req & wb_req_i.we;
  assign rd  = req & ~wb_req_i.we;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req;
    end
  end

  always_comb begin
    rdata_d = '0;
    case (wb_req_i.adr)
      tti_pkg::CONTROL:          rdata_d[tti_pkg::NumCtrl-1:0] = ctrl_q;
      tti_pkg::STATUS:           rdata_d[0] = err_q;
      tti_pkg::RESET_CONTROL:    rdata_d[2:0] = rst_ctrl_q;
      tti_pkg::INTERRUPT_STATUS: rdata_d[tti_pkg::NumIrq-1:0] = core_i.irq_sts;
      tti_pkg::INTERRUPT_ENABLE: rdata_d[tti_pkg::NumIrq-1:0] = ena_q;
      tti_pkg::QUEUE_THLD_CTRL:  rdata_d[15:0] = {data_thld_q, desc_thld_q};
      tti_pkg::RX_DESC_PORT: begin
        if (!rx_desc_sts_i.empty) begin
          rdata_d = rx_desc_head_i;
        end
      end
      tti_pkg::RX_DATA_PORT: begin
        if (!rx_data_sts_i.empty) begin
          rdata_d = rx_data_head_i;
        end
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rd) begin
      rdata_q <= rdata_d;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ctrl_q      <= '0;
      err_q       <= 1'b0;
      ena_q       <= '0;
      force_q     <= '0;
      desc_thld_q <= '0;
      data_thld_q <= '0;
      rst_ctrl_q  <= '0;
    end else begin
      // Flush and force bits live for one cycle
      rst_ctrl_q <= '0;
      force_q    <= '0;
      if (wr) begin
        case (wb_req_i.adr)
          tti_pkg::CONTROL:          ctrl_q <= wb_req_i.dat[tti_pkg::NumCtrl-1:0];
          tti_pkg::STATUS: begin
            if (wb_req_i.dat[0]) begin
              err_q <= 1'b0;
            end
          end
          tti_pkg::RESET_CONTROL:    rst_ctrl_q <= wb_req_i.dat[2:0];
          tti_pkg::INTERRUPT_ENABLE: ena_q <= wb_req_i.dat[tti_pkg::NumIrq-1:0];
          tti_pkg::INTERRUPT_FORCE:  force_q <= wb_req_i.dat[tti_pkg::NumIrq-1:0];
          tti_pkg::QUEUE_THLD_CTRL: begin
            desc_thld_q <= wb_req_i.dat[7:0];
            data_thld_q <= wb_req_i.dat[15:8];
          end
          default: ;
        endcase
      end
      // Target-side updates override software
      for (int i = 0; i < tti_pkg::NumCtrl; i++) begin
        if (core_i.ctrl_we[i]) begin
          ctrl_q[i] <= core_i.ctrl_next[i];
        end
      end
      if (core_i.err_set) begin
        err_q <= 1'b1;
      end
    end
  end

  always_comb begin
    csr_o.irq_ena       = ena_q;
    csr_o.irq_force     = force_q;
    csr_o.w1c_mask      = wb_req_i.dat[tti_pkg::NumIrq-1:0];
    csr_o.w1c_we        = wr & (wb_req_i.adr == tti_pkg::INTERRUPT_STATUS);
    csr_o.rx_desc_thld  = desc_thld_q;
    csr_o.rx_data_thld  = data_thld_q;
    csr_o.rx_desc_flush = rst_ctrl_q[0];
    csr_o.rx_data_flush = rst_ctrl_q[1];
    csr_o.tx_data_flush = rst_ctrl_q[2];
    csr_o.rx_desc_pop   = rd & (wb_req_i.adr == tti_pkg::RX_DESC_PORT) & ~rx_desc_sts_i.empty;
    csr_o.rx_data_pop   = rd & (wb_req_i.adr == tti_pkg::RX_DATA_PORT) & ~rx_data_sts_i.empty;
    csr_o.tx_data_push  = wr & (wb_req_i.adr == tti_pkg::TX_DATA_PORT);
  end

  assign wb_rsp_o.ack = ack_q;
  assign wb_rsp_o.dat = rdata_q;
  assign tx_wdata_o   = wb_req_i.dat;

endmodule

//--- hdl/tti_intr.sv
/* One interrupt status bit; a set or force in the same cycle as a clear wins. */
`timescale 1ns/1ps

module tti_intr (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic set_i,
  input  logic clr_i,
  input  logic w1c_i,
  input  logic force_i,
  input  logic ena_i,
  output logic sts_o,
  output logic irq_o
);

  logic sts_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sts_q <= 1'b0;
    end else if (set_i || force_i) begin
      sts_q <= 1'b1;
    end else if (clr_i || w1c_i) begin
      sts_q <= 1'b0;
    end
  end

  assign sts_o = sts_q;

  // Status is visible even when masked
  assign irq_o = sts_q & ena_i;

endmodule

//--- hdl/tti_pkg.sv
/* Types shared by the I3C target transaction interface.
   Wishbone data is always a full 32-bit word and offsets are byte addresses. */
package tti_pkg;

  localparam int unsigned DataWidth      = 32;
  localparam int unsigned AddrWidth      = 8;
  localparam int unsigned NumIrq         = 4;
  localparam int unsigned NumCtrl        = 3;
  localparam int unsigned FieldThldWidth = 8;

  // Word register offsets
  typedef enum logic [AddrWidth-1:0] {
    CONTROL          = 8'h00,
    STATUS           = 8'h04,
    RESET_CONTROL    = 8'h08,
    INTERRUPT_STATUS = 8'h0C,
    INTERRUPT_ENABLE = 8'h10,
    INTERRUPT_FORCE  = 8'h14,
    QUEUE_THLD_CTRL  = 8'h18,
    RX_DESC_PORT     = 8'h1C,
    RX_DATA_PORT     = 8'h20,
    TX_DATA_PORT     = 8'h24
  } tti_reg_e;

  // Bit positions in the interrupt registers
  typedef enum logic [1:0] {
    RX_DESC_STAT = 2'd0,
    RX_DESC_THLD = 2'd1,
    RX_DATA_THLD = 2'd2,
    TX_DONE      = 2'd3
  } tti_irq_e;

  typedef struct packed {
    logic                 cyc;
    logic                 stb;
    logic                 we;
    logic [AddrWidth-1:0] adr;
    logic [DataWidth-1:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic                 ack;
    logic [DataWidth-1:0] dat;
  } wb_rsp_t;

  // Pushes from the target-side protocol logic
  typedef struct packed {
    logic                 desc_wr;
    logic [DataWidth-1:0] desc_data;
    logic                 data_wr;
    logic [DataWidth-1:0] data_data;
  } tgt_rx_t;

  typedef struct packed {
    logic               tx_pr_end;
    logic [NumCtrl-1:0] enec;
    logic [NumCtrl-1:0] disec;
    logic               err;
  } tgt_evt_t;

  typedef struct packed {
    logic empty;
    logic full;
    logic thld_trig;
  } queue_sts_t;

  typedef struct packed {
    logic [NumIrq-1:0]         irq_ena;
    logic [NumIrq-1:0]         irq_force;
    logic [NumIrq-1:0]         w1c_mask;
    logic                      w1c_we;
    logic [FieldThldWidth-1:0] rx_desc_thld;
    logic [FieldThldWidth-1:0] rx_data_thld;
    logic                      rx_desc_flush;
    logic                      rx_data_flush;
    logic                      tx_data_flush;
    logic                      rx_desc_pop;
    logic                      rx_data_pop;
    logic                      tx_data_push;
  } csr_fields_t;

  typedef struct packed {
    logic [NumCtrl-1:0] ctrl_next;
    logic [NumCtrl-1:0] ctrl_we;
    logic               err_set;
    logic [NumIrq-1:0]  irq_sts;
  } core_fields_t;

endpackage

//--- hdl/tti_queue.sv
/* Show-ahead FIFO; pushes to a full queue and pops of an empty one are ignored.
   Flush takes priority over push and pop, and head is stale while empty. */
`timescale 1ns/1ps

module tti_queue #(
  parameter int unsigned Depth     = 4,
  parameter int unsigned ThldWidth = 8
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          push_i,
  input  logic [tti_pkg::DataWidth-1:0] push_data_i,
  input  logic                          pop_i,
  input  logic                          flush_i,
  input  logic [ThldWidth-1:0]          thld_i,
  output logic [tti_pkg::DataWidth-1:0] head_o,
  output tti_pkg::queue_sts_t           sts_o
);

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned LvlWidth = $clog2(Depth + 1);

  logic [tti_pkg::DataWidth-1:0] mem_q [Depth];
  logic [PtrWidth-1:0]           wptr_q;
  logic [PtrWidth-1:0]           rptr_q;
  logic [LvlWidth-1:0]           level_q;
  logic                          empty;
  logic                          full;
  logic                          push_ok;
  logic                          pop_ok;

  function automatic logic [PtrWidth-1:0] ptr_inc(input logic [PtrWidth-1:0] ptr);
    if (ptr == PtrWidth'(Depth - 1)) begin
      return '0;
    end
    return ptr + PtrWidth'(1);
  endfunction

  assign empty   = (level_q == '0);
  assign full    = (level_q == LvlWidth'(Depth));
  assign push_ok = push_i & ~full & ~flush_i;
  assign pop_ok  = pop_i & ~empty & ~flush_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      level_q <= '0;
    end else if (flush_i) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      level_q <= '0;
    end else begin
      if (push_ok) begin
        wptr_q <= ptr_inc(wptr_q);
      end
      if (pop_ok) begin
        rptr_q <= ptr_inc(rptr_q);
      end
      case ({push_ok, pop_ok})
        2'b10:   level_q <= level_q + LvlWidth'(1);
        2'b01:   level_q <= level_q - LvlWidth'(1);
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_ok) begin
      mem_q[wptr_q] <= push_data_i;
    end
  end

  assign head_o = mem_q[rptr_q];

  // Zero threshold disables the trigger
  assign sts_o.empty     = empty;
  assign sts_o.full      = full;
  assign sts_o.thld_trig = (thld_i != '0) && (32'(level_q) >= 32'(thld_i));

endmodule

//--- hdl/tti_top.sv
/* Target transaction interface top; the TX data queue runs without a threshold.
   Threshold fields wider than ThldWidth are truncated at the queues. */
`timescale 1ns/1ps

module tti_top #(
  parameter int unsigned RxDescDepth = 4,
  parameter int unsigned RxDataDepth = 8,
  parameter int unsigned TxDataDepth = 4,
  parameter int unsigned ThldWidth   = 8
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  tti_pkg::wb_req_t              wb_req_i,
  output tti_pkg::wb_rsp_t              wb_rsp_o,
  input  tti_pkg::tgt_rx_t              tgt_rx_i,
  input  tti_pkg::tgt_evt_t             tgt_evt_i,
  input  logic                          tx_data_rd_i,
  output logic [tti_pkg::DataWidth-1:0] tx_data_o,
  output logic                          tx_data_valid_o,
  output logic                          rx_desc_full_o,
  output logic                          rx_data_full_o,
  output logic                          irq_o
);

  tti_pkg::csr_fields_t          csr_fields;
  tti_pkg::core_fields_t         core_fields;
  tti_pkg::queue_sts_t           rx_desc_sts;
  tti_pkg::queue_sts_t           rx_data_sts;
  tti_pkg::queue_sts_t           tx_data_sts;
  logic [tti_pkg::DataWidth-1:0] rx_desc_head;
  logic [tti_pkg::DataWidth-1:0] rx_data_head;
  logic [tti_pkg::DataWidth-1:0] tx_wdata;

  tti_csr i_csr (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .wb_req_i       (wb_req_i),
    .wb_rsp_o       (wb_rsp_o),
    .core_i         (core_fields),
    .csr_o          (csr_fields),
    .rx_desc_head_i (rx_desc_head),
    .rx_data_head_i (rx_data_head),
    .rx_desc_sts_i  (rx_desc_sts),
    .rx_data_sts_i  (rx_data_sts),
    .tx_wdata_o     (tx_wdata)
  );

  tti_core i_core (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .csr_i         (csr_fields),
    .core_o        (core_fields),
    .tgt_rx_i      (tgt_rx_i),
    .tgt_evt_i     (tgt_evt_i),
    .rx_desc_sts_i (rx_desc_sts),
    .rx_data_sts_i (rx_data_sts),
    .irq_o         (irq_o)
  );

  tti_queue #(
    .Depth     (RxDescDepth),
    .ThldWidth (ThldWidth)
  ) i_rx_desc_queue (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .push_i      (tgt_rx_i.desc_wr),
    .push_data_i (tgt_rx_i.desc_data),
    .pop_i       (csr_fields.rx_desc_pop),
    .flush_i     (csr_fields.rx_desc_flush),
    .thld_i      (ThldWidth'(csr_fields.rx_desc_thld)),
    .head_o      (rx_desc_head),
    .sts_o       (rx_desc_sts)
  );

  tti_queue #(
    .Depth     (RxDataDepth),
    .ThldWidth (ThldWidth)
  ) i_rx_data_queue (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .push_i      (tgt_rx_i.data_wr),
    .push_data_i (tgt_rx_i.data_data),
    .pop_i       (csr_fields.rx_data_pop),
    .flush_i     (csr_fields.rx_data_flush),
    .thld_i      (ThldWidth'(csr_fields.rx_data_thld)),
    .head_o      (rx_data_head),
    .sts_o       (rx_data_sts)
  );

  tti_queue #(
    .Depth     (TxDataDepth),
    .ThldWidth (ThldWidth)
  ) i_tx_data_queue (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .push_i      (csr_fields.tx_data_push),
    .push_data_i (tx_wdata),
    .pop_i       (tx_data_rd_i),
    .flush_i     (csr_fields.tx_data_flush),
    .thld_i      ('0),
    .head_o      (tx_data_o),
    .sts_o       (tx_data_sts)
  );

  assign tx_data_valid_o = ~tx_data_sts.empty;
  assign rx_desc_full_o  = rx_desc_sts.full;
  assign rx_data_full_o  = rx_data_sts.full;

endmodule

//--- project.f
hdl/tti_pkg.sv
hdl/tti_intr.sv
hdl/tti_queue.sv
hdl/tti_csr.sv
hdl/tti_core.sv
hdl/tti_top.sv
verification/tti_clkgen.sv
verification/tti_sva.sv
verification/tti_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator; the log decides pass or fail

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f project.f --top-module tti_tb -Mdir obj_dir -o tti_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tti_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "Test completed successfully" "$LOG"; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi

//--- verification/tti_clkgen.sv
/* Clock and reset source for the testbench: 10 ns period.
   Reset is released 1 ns after the tenth rising edge. */
`timescale 1ns/1ps

module tti_clkgen #(
  parameter int unsigned ResetCycles = 10
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    #1;
    rst_no = 1'b1;
  end

endmodule

//--- verification/tti_sva.sv
/* Wishbone handshake and output checks, bound into tti_top.
   All checks are off while reset is asserted. */
`timescale 1ns/1ps

module tti_sva (
  input logic             clk_i,
  input logic             rst_ni,
  input tti_pkg::wb_req_t wb_req_i,
  input tti_pkg::wb_rsp_t wb_rsp_i,
  input logic             irq_i,
  input logic             rx_desc_full_i,
  input logic             rx_data_full_i,
  input logic             tx_data_valid_i
);

  // Ack only inside an active cycle
  ack_in_cycle: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    wb_rsp_i.ack |-> (wb_req_i.cyc && wb_req_i.stb)
  ) else $error("Wishbone ack raised without cyc and stb");

  // Classic slave acks each request once
  ack_single: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    wb_rsp_i.ack |=> !wb_rsp_i.ack
  ) else $error("Wishbone ack high for two cycles in a row");

  outputs_known: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !$isunknown({irq_i, rx_desc_full_i, rx_data_full_i, tx_data_valid_i})
  ) else $error("Unknown value on irq, full flags or tx valid");

  ack_known: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !$isunknown(wb_rsp_i.ack)
  ) else $error("Unknown value on Wishbone ack");

endmodule

//--- verification/tti_tb.sv
/* Testbench for the I3C target transaction interface, driving Wishbone and target pins.
   Inputs change 1 ns after the rising edge; expected data comes from reference queues. */
`timescale 1ns/1ps

module tti_tb;

  localparam int          RxDescDepth = 4;
  localparam int          RxDataDepth = 8;
  localparam int          TxDataDepth = 4;
  localparam int          ThldK       = 3;
  localparam int          CycleLimit  = 5000;
  localparam logic [31:0] Seed        = 32'ha99953ec;
  // Interrupt bit masks
  localparam logic [31:0] DescStatBit = 32'h1;
  localparam logic [31:0] DescThldBit = 32'h2;
  localparam logic [31:0] DataThldBit = 32'h4;
  localparam logic [31:0] TxDoneBit   = 32'h8;

  logic                  clk;
  logic                  rst_n;
  tti_pkg::wb_req_t      wb_req;
  tti_pkg::wb_rsp_t      wb_rsp;
  tti_pkg::tgt_rx_t      tgt_rx;
  tti_pkg::tgt_evt_t     tgt_evt;
  logic                  tx_data_rd;
  logic [31:0]           tx_data;
  logic                  tx_data_valid;
  logic                  rx_desc_full;
  logic                  rx_data_full;
  logic                  irq;
  int                    errors;
  int                    cycles;
  logic [31:0]           desc_model[$];
  logic [31:0]           data_model[$];
  logic [31:0]           tx_model[$];

  tti_clkgen i_clkgen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  tti_top #(
    .RxDescDepth (RxDescDepth),
    .RxDataDepth (RxDataDepth),
    .TxDataDepth (TxDataDepth),
    .ThldWidth   (8)
  ) i_dut (
    .clk_i           (clk),
    .rst_ni          (rst_n),
    .wb_req_i        (wb_req),
    .wb_rsp_o        (wb_rsp),
    .tgt_rx_i        (tgt_rx),
    .tgt_evt_i       (tgt_evt),
    .tx_data_rd_i    (tx_data_rd),
    .tx_data_o       (tx_data),
    .tx_data_valid_o (tx_data_valid),
    .rx_desc_full_o  (rx_desc_full),
    .rx_data_full_o  (rx_data_full),
    .irq_o           (irq)
  );

  bind tti_top tti_sva i_sva (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .wb_req_i        (wb_req_i),
    .wb_rsp_i        (wb_rsp_o),
    .irq_i           (irq_o),
    .rx_desc_full_i  (rx_desc_full_o),
    .rx_data_full_i  (rx_data_full_o),
    .tx_data_valid_i (tx_data_valid_o)
  );

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    assert (got === exp) else begin
      $display("Error: %0d ns: %s, got %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  // Holds cyc and stb until ack is sampled at a rising edge
  task automatic wb_access(input logic we, input tti_pkg::tti_reg_e adr,
                           input logic [31:0] wdata, output logic [31:0] rdata);
    @(posedge clk);
    #1;
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = we;
    wb_req.adr = adr;
    wb_req.dat = wdata;
    do begin
      @(posedge clk);
      #1;
    end while (!wb_rsp.ack);
    rdata = wb_rsp.dat;
    @(posedge clk);
    #1;
    wb_req.cyc = 1'b0;
    wb_req.stb = 1'b0;
    wb_req.we  = 1'b0;
  endtask

  task automatic wb_write(input tti_pkg::tti_reg_e adr, input logic [31:0] wdata);
    logic [31:0] unused_rdata;
    wb_access(1'b1, adr, wdata, unused_rdata);
  endtask

  task automatic read_check(input tti_pkg::tti_reg_e adr, input logic [31:0] mask,
                            input logic [31:0] exp, input string what);
    logic [31:0] rdata;
    wb_access(1'b0, adr, '0, rdata);
    check_eq(rdata & mask, exp, what);
  endtask

  // One-cycle target push; the model drops words once the queue is full
  task automatic rx_push(input logic to_desc, input logic [31:0] word);
    @(posedge clk);
    #1;
    if (to_desc) begin
      tgt_rx.desc_wr   = 1'b1;
      tgt_rx.desc_data = word;
      if (desc_model.size() < RxDescDepth) begin
        desc_model.push_back(word);
      end
    end else begin
      tgt_rx.data_wr   = 1'b1;
      tgt_rx.data_data = word;
      if (data_model.size() < RxDataDepth) begin
        data_model.push_back(word);
      end
    end
    @(posedge clk);
    #1;
    tgt_rx.desc_wr = 1'b0;
    tgt_rx.data_wr = 1'b0;
  endtask

  task automatic drain_rx(input logic from_desc);
    if (from_desc) begin
      while (desc_model.size() > 0) begin
        read_check(tti_pkg::RX_DESC_PORT, '1, desc_model.pop_front(), "RX desc order");
      end
    end else begin
      while (data_model.size() > 0) begin
        read_check(tti_pkg::RX_DATA_PORT, '1, data_model.pop_front(), "RX data order");
      end
    end
  endtask

  task automatic tx_write(input logic [31:0] word);
    wb_write(tti_pkg::TX_DATA_PORT, word);
    if (tx_model.size() < TxDataDepth) begin
      tx_model.push_back(word);
    end
  endtask

  task automatic tx_pop_check(input logic [31:0] exp);
    check_eq(32'(tx_data_valid), 32'd1, "TX valid before pop");
    check_eq(tx_data, exp, "TX data order");
    @(posedge clk);
    #1;
    tx_data_rd = 1'b1;
    @(posedge clk);
    #1;
    tx_data_rd = 1'b0;
  endtask

  function automatic tti_pkg::tgt_evt_t make_event(input logic tx_pr_end, input logic [2:0] enec,
                                                   input logic [2:0] disec, input logic err);
    tti_pkg::tgt_evt_t evt;
    evt.tx_pr_end = tx_pr_end;
    evt.enec      = enec;
    evt.disec     = disec;
    evt.err       = err;
    return evt;
  endfunction

  task automatic pulse_event(input tti_pkg::tgt_evt_t evt);
    @(posedge clk);
    #1;
    tgt_evt = evt;
    @(posedge clk);
    #1;
    tgt_evt = '0;
  endtask

  task automatic wait_irq(input logic level, input int max_cycles, input string what);
    int n;
    n = 0;
    while (irq !== level && n < max_cycles) begin
      @(posedge clk);
      #1;
      n++;
    end
    check_eq(32'(irq), 32'(level), what);
  endtask

  task automatic idle(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  // Tests take well under 1000 cycles
  initial begin
    cycles = 0;
    while (cycles < CycleLimit) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: no end of test after %0d clock cycles", CycleLimit);
    $display("Test failed");
    $finish;
  end

  initial begin
    int i;
    errors     = 0;
    wb_req     = '0;
    tgt_rx     = '0;
    tgt_evt    = '0;
    tx_data_rd = 1'b0;
    void'($urandom(Seed));
    @(posedge rst_n);

    // Reset values
    check_eq(32'(irq), 32'd0, "irq after reset");
    read_check(tti_pkg::CONTROL, '1, 32'd0, "CONTROL after reset");
    read_check(tti_pkg::STATUS, '1, 32'd0, "STATUS after reset");
    read_check(tti_pkg::INTERRUPT_STATUS, '1, 32'd0, "INTERRUPT_STATUS after reset");
    read_check(tti_pkg::INTERRUPT_ENABLE, '1, 32'd0, "INTERRUPT_ENABLE after reset");

    // RX queues overfilled, then drained in order
    for (i = 0; i < RxDescDepth + 2; i++) begin
      rx_push(1'b1, $urandom);
    end
    for (i = 0; i < RxDataDepth + 2; i++) begin
      rx_push(1'b0, $urandom);
    end
    check_eq(32'(rx_desc_full), 32'd1, "RX desc full flag");
    check_eq(32'(rx_data_full), 32'd1, "RX data full flag");
    drain_rx(1'b1);
    drain_rx(1'b0);
    check_eq(32'(rx_desc_full), 32'd0, "RX desc full after drain");
    read_check(tti_pkg::RX_DESC_PORT, '1, 32'd0, "empty RX desc port");
    read_check(tti_pkg::RX_DATA_PORT, '1, 32'd0, "empty RX data port");

    // TX path with overflow, then flush
    for (i = 0; i < TxDataDepth + 2; i++) begin
      tx_write($urandom);
    end
    while (tx_model.size() > 0) begin
      tx_pop_check(tx_model.pop_front());
    end
    check_eq(32'(tx_data_valid), 32'd0, "TX valid after draining");
    tx_write($urandom);
    tx_write($urandom);
    check_eq(32'(tx_data_valid), 32'd1, "TX valid before flush");
    wb_write(tti_pkg::RESET_CONTROL, 32'h4);
    tx_model.delete();
    check_eq(32'(tx_data_valid), 32'd0, "TX valid after flush");
    read_check(tti_pkg::RESET_CONTROL, '1, 32'd0, "RESET_CONTROL self clear");

    // Descriptor status interrupt
    wb_write(tti_pkg::INTERRUPT_ENABLE, DescStatBit);
    rx_push(1'b1, $urandom);
    wait_irq(1'b1, 10, "irq from RX descriptor push");
    read_check(tti_pkg::INTERRUPT_STATUS, DescStatBit, DescStatBit, "RX_DESC_STAT set");
    drain_rx(1'b1);
    check_eq(32'(irq), 32'd0, "irq after descriptor pop");
    read_check(tti_pkg::INTERRUPT_STATUS, DescStatBit, 32'd0, "RX_DESC_STAT cleared");

    // TX_DONE holds until write-1-clear
    pulse_event(make_event(1'b1, 3'b000, 3'b000, 1'b0));
    read_check(tti_pkg::INTERRUPT_STATUS, TxDoneBit, TxDoneBit, "TX_DONE set");
    idle(5);
    read_check(tti_pkg::INTERRUPT_STATUS, TxDoneBit, TxDoneBit, "TX_DONE held");
    check_eq(32'(irq), 32'd0, "irq with TX_DONE masked");
    wb_write(tti_pkg::INTERRUPT_STATUS, TxDoneBit);
    read_check(tti_pkg::INTERRUPT_STATUS, TxDoneBit, 32'd0, "TX_DONE after W1C");

    // Force sets status, irq only once enabled
    wb_write(tti_pkg::INTERRUPT_ENABLE, 32'd0);
    wb_write(tti_pkg::INTERRUPT_FORCE, DescThldBit);
    read_check(tti_pkg::INTERRUPT_STATUS, '1, DescThldBit, "forced RX_DESC_THLD");
    read_check(tti_pkg::INTERRUPT_FORCE, '1, 32'd0, "INTERRUPT_FORCE reads 0");
    check_eq(32'(irq), 32'd0, "irq with forced bit masked");
    wb_write(tti_pkg::INTERRUPT_ENABLE, DescThldBit);
    check_eq(32'(irq), 32'd1, "irq with forced bit enabled");
    wb_write(tti_pkg::INTERRUPT_STATUS, DescThldBit);
    check_eq(32'(irq), 32'd0, "irq after forced bit W1C");
    wb_write(tti_pkg::INTERRUPT_ENABLE, 32'd0);

    // RX data threshold at K, then at 0
    wb_write(tti_pkg::QUEUE_THLD_CTRL, 32'(ThldK) << 8);
    for (i = 0; i < ThldK - 1; i++) begin
      rx_push(1'b0, $urandom);
    end
    idle(2);
    read_check(tti_pkg::INTERRUPT_STATUS, DataThldBit, 32'd0, "RX_DATA_THLD below threshold");
    rx_push(1'b0, $urandom);
    idle(2);
    read_check(tti_pkg::INTERRUPT_STATUS, DataThldBit, DataThldBit, "RX_DATA_THLD at threshold");
    drain_rx(1'b0);
    read_check(tti_pkg::INTERRUPT_STATUS, DataThldBit, 32'd0, "RX_DATA_THLD after pop");
    wb_write(tti_pkg::QUEUE_THLD_CTRL, 32'd0);
    for (i = 0; i < ThldK + 1; i++) begin
      rx_push(1'b0, $urandom);
    end
    idle(2);
    read_check(tti_pkg::INTERRUPT_STATUS, DataThldBit, 32'd0, "RX_DATA_THLD with zero threshold");
    drain_rx(1'b0);

    // ENEC, DISEC and protocol error
    pulse_event(make_event(1'b0, 3'b101, 3'b000, 1'b0));
    read_check(tti_pkg::CONTROL, '1, 32'h5, "CONTROL after ENEC");
    pulse_event(make_event(1'b0, 3'b000, 3'b001, 1'b0));
    read_check(tti_pkg::CONTROL, '1, 32'h4, "CONTROL after DISEC");
    pulse_event(make_event(1'b0, 3'b010, 3'b010, 1'b0));
    read_check(tti_pkg::CONTROL, '1, 32'h6, "CONTROL with ENEC and DISEC together");
    wb_write(tti_pkg::CONTROL, 32'd0);
    read_check(tti_pkg::CONTROL, '1, 32'd0, "CONTROL software write");
    pulse_event(make_event(1'b0, 3'b000, 3'b000, 1'b1));
    read_check(tti_pkg::STATUS, '1, 32'h1, "STATUS error set");
    wb_write(tti_pkg::STATUS, 32'd0);
    read_check(tti_pkg::STATUS, '1, 32'h1, "STATUS error held");
    wb_write(tti_pkg::STATUS, 32'h1);
    read_check(tti_pkg::STATUS, '1, 32'd0, "STATUS error cleared");

    idle(4);
    $display("Checks finished with %0d error(s) after %0d cycles", errors, cycles);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
